// ==== hw/mempool_cfg_pkg.sv ====
// ****************************************
// Group sizes and TCDM address widths
// Read by scoped name from every RTL file
// ****************************************

package mempool_cfg_pkg;

  // One bank per tile
  localparam int unsigned NumTilesPerGroup = 4;
  localparam int unsigned TileIdxWidth     = 2;

  // Words inside one bank
  localparam int unsigned BankRowWidth     = 8;

  // Word address, row above tile index
  localparam int unsigned TCDMAddrWidth    = BankRowWidth + TileIdxWidth;

  localparam int unsigned DataWidth        = 32;
  localparam int unsigned StrbWidth        = DataWidth / 8;

endpackage : mempool_cfg_pkg

// ==== hw/tcdm_pkg.sv ====
// ****************************************
// TCDM request and response payload types
// ****************************************

package tcdm_pkg;

  typedef logic [mempool_cfg_pkg::TileIdxWidth-1:0] tile_idx_t;
  typedef logic [mempool_cfg_pkg::BankRowWidth-1:0] bank_row_t;
  typedef logic [mempool_cfg_pkg::DataWidth-1:0]    data_t;
  typedef logic [mempool_cfg_pkg::StrbWidth-1:0]    strb_t;

  // Low bits pick the tile so consecutive words interleave
  typedef struct packed {
    bank_row_t row;
    tile_idx_t tile;
  } tcdm_addr_fields_t;

  // Flat for masters, split for the crossbar and banks
  typedef union packed {
    logic [mempool_cfg_pkg::TCDMAddrWidth-1:0] word;
    tcdm_addr_fields_t                         fields;
  } tcdm_addr_u;

  typedef struct packed {
    tcdm_addr_u addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } tcdm_req_t;

  typedef struct packed {
    bank_row_t row;
    tile_idx_t ini;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } tcdm_bank_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  typedef struct packed {
    tile_idx_t ini;
    data_t     rdata;
  } tcdm_bank_resp_t;

endpackage : tcdm_pkg

// ==== hw/rr_arbiter.sv ====
// ****************************************
// Round-robin arbiter, one-hot grant
// Pointer moves only when the grant is taken
// ****************************************

module rr_arbiter #(
  parameter int unsigned NumReq = 4
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic [NumReq-1:0] req_i,
  output logic [NumReq-1:0] gnt_o,
  input  logic              ready_i
);

  // Set bits mark requesters at or after the pointer
  logic [NumReq-1:0] prio_mask_q;
  logic [NumReq-1:0] prio_mask_d;
  logic [NumReq-1:0] req_masked;
  logic [NumReq-1:0] gnt_masked;
  logic [NumReq-1:0] gnt_plain;

  assign req_masked = req_i & prio_mask_q;

  // Isolate the lowest set bit
  assign gnt_masked = req_masked & (~req_masked + 1'b1);
  assign gnt_plain  = req_i & (~req_i + 1'b1);

  // Wrap to index 0 when nothing is left above the pointer
  assign gnt_o = (req_masked != '0) ? gnt_masked : gnt_plain;

  // Everything strictly above the winner
  assign prio_mask_d = ~((gnt_o << 1) - 1'b1);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_mask_q <= '1;
    end else if (ready_i && (gnt_o != '0)) begin
      prio_mask_q <= prio_mask_d;
    end
  end

  gnt_onehot_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o)
  ) else $error("Arbiter granted more than one requester");

  gnt_to_req_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o & ~req_i) == '0
  ) else $error("Arbiter granted an idle requester");

endmodule : rr_arbiter

// ==== hw/tcdm_local_xbar.sv ====
// ****************************************
// Word-interleaved tile-to-bank crossbar
// Combinational both ways, arbitrated per bank and per tile
// ****************************************

module tcdm_local_xbar (
  input  logic                                                          clk_i,
  input  logic                                                          arst_n_i,
  // Tile side
  input  tcdm_pkg::tcdm_req_t       [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_i,
  input  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_valid_i,
  output logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_ready_o,
  output tcdm_pkg::tcdm_resp_t      [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_o,
  output logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_valid_o,
  input  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_ready_i,
  // Bank side
  output tcdm_pkg::tcdm_bank_req_t  [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req_o,
  output logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req_valid_o,
  input  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req_ready_i,
  input  tcdm_pkg::tcdm_bank_resp_t [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp_i,
  input  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp_valid_i,
  output logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp_ready_o
);

  // Indexed [bank][tile]
  logic [mempool_cfg_pkg::NumTilesPerGroup-1:0][mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_hit;
  logic [mempool_cfg_pkg::NumTilesPerGroup-1:0][mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_gnt;
  // Indexed [tile][bank]
  logic [mempool_cfg_pkg::NumTilesPerGroup-1:0][mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_hit;
  logic [mempool_cfg_pkg::NumTilesPerGroup-1:0][mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_gnt;

  for (genvar b = 0; b < mempool_cfg_pkg::NumTilesPerGroup; b++) begin : gen_bank_arb
    tcdm_pkg::tcdm_bank_req_t sel_req;

    for (genvar t = 0; t < mempool_cfg_pkg::NumTilesPerGroup; t++) begin : gen_hit
      assign bank_hit[b][t] = req_valid_i[t] &&
                              (req_i[t].addr.fields.tile == tcdm_pkg::tile_idx_t'(b));
    end

    rr_arbiter #(
      .NumReq(mempool_cfg_pkg::NumTilesPerGroup)
    ) i_bank_arb (
      .clk_i   (clk_i              ),
      .arst_n_i(arst_n_i           ),
      .req_i   (bank_hit[b]        ),
      .gnt_o   (bank_gnt[b]        ),
      .ready_i (bank_req_ready_i[b])
    );

    // Winner's payload, stamped with its tile index
    always_comb begin
      sel_req = '0;
      for (int unsigned t = 0; t < mempool_cfg_pkg::NumTilesPerGroup; t++) begin
        if (bank_gnt[b][t]) begin
          sel_req.row   = req_i[t].addr.fields.row;
          sel_req.ini   = tcdm_pkg::tile_idx_t'(t);
          sel_req.wen   = req_i[t].wen;
          sel_req.wdata = req_i[t].wdata;
          sel_req.be    = req_i[t].be;
        end
      end
    end

    assign bank_req_o[b]       = sel_req;
    assign bank_req_valid_o[b] = |bank_hit[b];

    // An unknown ini would match no tile and strand the response
    ini_in_range_a: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      bank_resp_valid_i[b] |->
        !$isunknown(bank_resp_i[b].ini) &&
        (bank_resp_i[b].ini <= tcdm_pkg::tile_idx_t'(mempool_cfg_pkg::NumTilesPerGroup - 1))
    ) else $error("Bank response addressed to a missing tile");
  end

  always_comb begin
    req_ready_o = '0;
    for (int unsigned b = 0; b < mempool_cfg_pkg::NumTilesPerGroup; b++) begin
      req_ready_o |= bank_gnt[b] & {mempool_cfg_pkg::NumTilesPerGroup{bank_req_ready_i[b]}};
    end
  end

  for (genvar t = 0; t < mempool_cfg_pkg::NumTilesPerGroup; t++) begin : gen_resp_arb
    tcdm_pkg::data_t sel_rdata;

    for (genvar b = 0; b < mempool_cfg_pkg::NumTilesPerGroup; b++) begin : gen_hit
      assign resp_hit[t][b] = bank_resp_valid_i[b] &&
                              (bank_resp_i[b].ini == tcdm_pkg::tile_idx_t'(t));
    end

    rr_arbiter #(
      .NumReq(mempool_cfg_pkg::NumTilesPerGroup)
    ) i_resp_arb (
      .clk_i   (clk_i          ),
      .arst_n_i(arst_n_i       ),
      .req_i   (resp_hit[t]    ),
      .gnt_o   (resp_gnt[t]    ),
      .ready_i (resp_ready_i[t])
    );

    always_comb begin
      sel_rdata = '0;
      for (int unsigned b = 0; b < mempool_cfg_pkg::NumTilesPerGroup; b++) begin
        if (resp_gnt[t][b]) begin
          sel_rdata = bank_resp_i[b].rdata;
        end
      end
    end

    assign resp_o[t].rdata = sel_rdata;
    assign resp_valid_o[t] = |resp_hit[t];
  end

  always_comb begin
    bank_resp_ready_o = '0;
    for (int unsigned t = 0; t < mempool_cfg_pkg::NumTilesPerGroup; t++) begin
      bank_resp_ready_o |= resp_gnt[t] & {mempool_cfg_pkg::NumTilesPerGroup{resp_ready_i[t]}};
    end
  end

endmodule : tcdm_local_xbar

// ==== hw/tcdm_tile_bank.sv ====
// ****************************************
// Single tile memory bank, one-cycle access
// Response held in a one-entry register
// ****************************************

module tcdm_tile_bank (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  tcdm_pkg::tcdm_bank_req_t  req_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output tcdm_pkg::tcdm_bank_resp_t resp_o,
  output logic                      resp_valid_o,
  input  logic                      resp_ready_i
);

  tcdm_pkg::data_t           mem_q [2**mempool_cfg_pkg::BankRowWidth];
  tcdm_pkg::data_t           new_word;
  tcdm_pkg::tcdm_bank_resp_t resp_q;
  logic                      resp_valid_q;
  logic                      req_fire;

  // Free slot, or the held response leaves this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  // Byte merge; a read leaves the word untouched
  always_comb begin
    new_word = mem_q[req_i.row];
    for (int unsigned i = 0; i < mempool_cfg_pkg::StrbWidth; i++) begin
      if (req_i.wen && req_i.be[i]) begin
        new_word[8*i +: 8] = req_i.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.wen) begin
        mem_q[req_i.row] <= new_word;
      end
      resp_q.ini   <= req_i.ini;
      resp_q.rdata <= new_word;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // Stalled response must not move or vanish
  resp_stable_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o)
  ) else $error("Bank response changed while stalled");

endmodule : tcdm_tile_bank

// ==== hw/mempool_group.sv ====
// ****************************************
// Group top: local crossbar and tile banks
// ****************************************

module mempool_group (
  input  logic                                                     clk_i,
  input  logic                                                     arst_n_i,
  input  tcdm_pkg::tcdm_req_t  [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_i,
  input  logic                 [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_valid_i,
  output logic                 [mempool_cfg_pkg::NumTilesPerGroup-1:0] req_ready_o,
  output tcdm_pkg::tcdm_resp_t [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_o,
  output logic                 [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_valid_o,
  input  logic                 [mempool_cfg_pkg::NumTilesPerGroup-1:0] resp_ready_i
);

  tcdm_pkg::tcdm_bank_req_t  [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req;
  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req_valid;
  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_req_ready;
  tcdm_pkg::tcdm_bank_resp_t [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp;
  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp_valid;
  logic                      [mempool_cfg_pkg::NumTilesPerGroup-1:0] bank_resp_ready;

  tcdm_local_xbar i_local_interco (
    .clk_i            (clk_i          ),
    .arst_n_i         (arst_n_i       ),
    .req_i            (req_i          ),
    .req_valid_i      (req_valid_i    ),
    .req_ready_o      (req_ready_o    ),
    .resp_o           (resp_o         ),
    .resp_valid_o     (resp_valid_o   ),
    .resp_ready_i     (resp_ready_i   ),
    .bank_req_o       (bank_req       ),
    .bank_req_valid_o (bank_req_valid ),
    .bank_req_ready_i (bank_req_ready ),
    .bank_resp_i      (bank_resp      ),
    .bank_resp_valid_i(bank_resp_valid),
    .bank_resp_ready_o(bank_resp_ready)
  );

  for (genvar b = 0; b < mempool_cfg_pkg::NumTilesPerGroup; b++) begin : gen_banks
    tcdm_tile_bank i_bank (
      .clk_i       (clk_i             ),
      .arst_n_i    (arst_n_i          ),
      .req_i       (bank_req[b]       ),
      .req_valid_i (bank_req_valid[b] ),
      .req_ready_o (bank_req_ready[b] ),
      .resp_o      (bank_resp[b]      ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end

endmodule : mempool_group

// ==== verification/mempool_group_tb.sv ====
// ****************************************
// Testbench for the group TCDM path
// Replays request groups from the tests file
// ****************************************

module mempool_group_tb;

  localparam int unsigned NumTiles      = mempool_cfg_pkg::NumTilesPerGroup;
  localparam int unsigned FieldsPerLine = 9;
  localparam int unsigned MaxLines      = 64;

  // Column offsets inside one test line
  localparam int unsigned FGroup = 0;
  localparam int unsigned FTile  = 1;
  localparam int unsigned FWen   = 2;
  localparam int unsigned FAddr  = 3;
  localparam int unsigned FWdata = 4;
  localparam int unsigned FBe    = 5;
  localparam int unsigned FExp   = 6;
  localparam int unsigned FCheck = 7;
  localparam int unsigned FStall = 8;

  logic                                 clk_i;
  logic                                 arst_n_i;
  tcdm_pkg::tcdm_req_t  [NumTiles-1:0]  req;
  logic                 [NumTiles-1:0]  req_valid;
  logic                 [NumTiles-1:0]  req_ready;
  tcdm_pkg::tcdm_resp_t [NumTiles-1:0]  resp;
  logic                 [NumTiles-1:0]  resp_valid;
  logic                 [NumTiles-1:0]  resp_ready;

  logic [31:0] test_words [FieldsPerLine*MaxLines];
  int unsigned num_lines;
  int unsigned cycle_cnt;
  int unsigned cycle_limit = 0;

  mempool_group dut (
    .clk_i       (clk_i     ),
    .arst_n_i    (arst_n_i  ),
    .req_i       (req       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .resp_o      (resp      ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  function automatic logic [31:0] test_field(input int unsigned line, input int unsigned col);
    return test_words[line*FieldsPerLine + col];
  endfunction

  function automatic tcdm_pkg::tcdm_req_t make_req(input int unsigned line);
    tcdm_pkg::tcdm_req_t r;
    logic [31:0]         addr_w;
    logic [31:0]         be_w;
    r           = '0;
    addr_w      = test_field(line, FAddr);
    be_w        = test_field(line, FBe);
    r.addr.word = addr_w[mempool_cfg_pkg::TCDMAddrWidth-1:0];
    r.wen       = (test_field(line, FWen) != 0);
    r.wdata     = test_field(line, FWdata);
    r.be        = be_w[mempool_cfg_pkg::StrbWidth-1:0];
    return r;
  endfunction

  // Issues one group and waits for all of its responses
  task automatic run_group(input int unsigned first, output int unsigned next);
    logic [31:0]         grp;
    int unsigned         idx;
    int unsigned         t;
    int unsigned         bank;
    int unsigned         line_of    [NumTiles];
    int unsigned         accept_cyc [NumTiles];
    int unsigned         stall_left [NumTiles];
    logic [31:0]         held_rdata [NumTiles];
    logic [NumTiles-1:0] in_group;
    logic [NumTiles-1:0] wait_req;
    logic [NumTiles-1:0] wait_resp;
    logic [NumTiles-1:0] resp_seen;
    logic [NumTiles-1:0] drop_req;
    logic [NumTiles-1:0] raise_ready;
    logic [NumTiles-1:0] banks_used;
    logic                exact_latency;

    grp           = test_field(first, FGroup);
    idx           = first;
    in_group      = '0;
    banks_used    = '0;
    exact_latency = 1'b1;
    while (idx < num_lines && test_field(idx, FGroup) == grp) begin
      t = test_field(idx, FTile);
      assert (t < NumTiles && !in_group[t])
        else stop_on_error($sformatf("ERROR: test line %0d has a bad or repeated tile", idx));
      // Low address bits pick the bank
      bank = test_field(idx, FAddr) % NumTiles;
      if (banks_used[bank]) begin
        exact_latency = 1'b0;
      end
      banks_used[bank] = 1'b1;
      line_of[t]       = idx;
      stall_left[t]    = test_field(idx, FStall);
      in_group[t]      = 1'b1;
      idx++;
    end
    next = idx;

    @(posedge clk_i);
    for (t = 0; t < NumTiles; t++) begin
      if (in_group[t]) begin
        req[t]        <= make_req(line_of[t]);
        req_valid[t]  <= 1'b1;
        resp_ready[t] <= (stall_left[t] == 0);
      end
    end

    wait_req  = in_group;
    wait_resp = in_group;
    resp_seen = '0;
    while (wait_req != '0 || wait_resp != '0) begin
      @(negedge clk_i);
      drop_req    = '0;
      raise_ready = '0;
      for (t = 0; t < NumTiles; t++) begin
        if (resp_valid[t]) begin
          assert (wait_resp[t] && !wait_req[t])
            else stop_on_error($sformatf("ERROR: tile %0d got a response it did not ask for", t));
          if (!resp_seen[t]) begin
            resp_seen[t]  = 1'b1;
            held_rdata[t] = resp[t].rdata;
            if (exact_latency && test_field(line_of[t], FStall) == 0) begin
              assert (cycle_cnt - accept_cyc[t] == 1)
                else stop_on_error($sformatf(
                  "MISMATCH at time %0t: tile %0d response after %0d cycles, expected 1",
                  $time, t, cycle_cnt - accept_cyc[t]));
            end
          end
          assert (resp[t].rdata === held_rdata[t])
            else stop_on_error($sformatf(
              "MISMATCH at time %0t: tile %0d response changed from %h to %h while waiting",
              $time, t, held_rdata[t], resp[t].rdata));
          if (resp_ready[t]) begin
            if (test_field(line_of[t], FCheck) != 0) begin
              assert (resp[t].rdata === test_field(line_of[t], FExp))
                else stop_on_error($sformatf(
                  "MISMATCH at time %0t: tile %0d read %h, expected %h",
                  $time, t, resp[t].rdata, test_field(line_of[t], FExp)));
            end
            wait_resp[t] = 1'b0;
          end else begin
            stall_left[t]--;
            if (stall_left[t] == 0) begin
              raise_ready[t] = 1'b1;
            end
          end
        end
        if (wait_req[t] && req_ready[t]) begin
          accept_cyc[t] = cycle_cnt;
          wait_req[t]   = 1'b0;
          drop_req[t]   = 1'b1;
        end
      end
      @(posedge clk_i);
      for (t = 0; t < NumTiles; t++) begin
        if (drop_req[t]) begin
          req_valid[t] <= 1'b0;
        end
        if (raise_ready[t]) begin
          resp_ready[t] <= 1'b1;
        end
      end
    end
  endtask

  // Cycle limit scales with the number of test lines
  initial begin
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      assert (cycle_cnt < cycle_limit)
        else stop_on_error($sformatf("ERROR: timeout after %0d cycles, no response arrived",
                                     cycle_cnt));
    end
  end

  initial begin
    int unsigned line_idx;
    int unsigned next_idx;

    arst_n_i   = 1'b0;
    req        = '0;
    req_valid  = '0;
    resp_ready = '1;

    // All ones marks lines past the end of the file
    foreach (test_words[i]) begin
      test_words[i] = '1;
    end
    $readmemh("verification/mempool_group_tests.txt", test_words);
    num_lines = 0;
    while (num_lines < MaxLines && test_words[num_lines*FieldsPerLine] != '1) begin
      num_lines++;
    end
    assert (num_lines > 0)
      else stop_on_error("ERROR: no test lines were loaded from the tests file");
    cycle_limit = num_lines * 20 + 100;

    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    repeat (3) begin
      @(negedge clk_i);
      assert (resp_valid == '0)
        else stop_on_error("ERROR: response valid is high before any request");
    end

    line_idx = 0;
    while (line_idx < num_lines) begin
      run_group(line_idx, next_idx);
      line_idx = next_idx;
    end

    // Nothing may trail the last group
    repeat (3) begin
      @(negedge clk_i);
      assert (resp_valid == '0)
        else stop_on_error("ERROR: an extra response appeared after all requests were served");
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : mempool_group_tb

// ==== mempool_group.f ====
hw/mempool_cfg_pkg.sv
hw/tcdm_pkg.sv
hw/rr_arbiter.sv
hw/tcdm_local_xbar.sv
hw/tcdm_tile_bank.sv
hw/mempool_group.sv
verification/mempool_group_tb.sv

// ==== Bender.yml ====
package:
  name: mempool_group

sources:
  - files:
      - hw/mempool_cfg_pkg.sv
      - hw/tcdm_pkg.sv
      - hw/rr_arbiter.sv
      - hw/tcdm_local_xbar.sv
      - hw/tcdm_tile_bank.sv
      - hw/mempool_group.sv
  - target: test
    files:
      - verification/mempool_group_tb.sv

// ==== verification/mempool_group_tests.txt ====
// group tile wen addr wdata be exp_rdata check stall
// hex fields, one request per line; lines of one group issue together
00 0 1 004 11223344 f 11223344 1 0
01 0 0 004 00000000 0 11223344 1 0
02 1 1 005 a5a5a5a5 f a5a5a5a5 1 0
03 1 1 005 12345678 5 a534a578 1 0
04 1 0 005 00000000 0 a534a578 1 0
05 0 1 010 cafe0000 f cafe0000 1 0
05 1 1 011 cafe0001 f cafe0001 1 0
05 2 1 012 cafe0002 f cafe0002 1 0
05 3 1 013 cafe0003 f cafe0003 1 0
06 0 0 013 00000000 0 cafe0003 1 0
06 1 0 010 00000000 0 cafe0000 1 0
06 2 0 011 00000000 0 cafe0001 1 0
06 3 0 012 00000000 0 cafe0002 1 0
07 0 0 010 00000000 0 cafe0000 1 0
07 1 0 004 00000000 0 11223344 1 0
07 2 0 010 00000000 0 cafe0000 1 0
07 3 0 004 00000000 0 11223344 1 0
08 0 1 022 0a0a0a0a f 0a0a0a0a 1 0
08 1 1 026 1b1b1b1b f 1b1b1b1b 1 0
08 2 1 02a 2c2c2c2c f 2c2c2c2c 1 0
08 3 1 02e 3d3d3d3d f 3d3d3d3d 1 0
09 0 0 02e 00000000 0 3d3d3d3d 1 0
09 1 0 02a 00000000 0 2c2c2c2c 1 0
09 2 0 026 00000000 0 1b1b1b1b 1 0
09 3 0 022 00000000 0 0a0a0a0a 1 0
0a 2 0 012 00000000 0 cafe0002 1 5
0b 0 0 013 00000000 0 cafe0003 1 3
0b 3 0 013 00000000 0 cafe0003 1 0
0c 3 1 013 ff000000 8 fffe0003 1 2
0d 2 0 013 00000000 0 fffe0003 1 0
0d 1 0 005 00000000 0 a534a578 1 0
0e 0 1 030 0000beef 3 00000000 0 0
